/* logic/cmd_cfg_pkg.sv */
// Stream widths, reply limits, user reset length, build identifier and command codes
package cmd_cfg_pkg;

  // Core stream word
  localparam int DAT_BYTS = 8;
  localparam int DAT_BITS = DAT_BYTS * 8;
  localparam int MOD_BITS = $clog2(DAT_BYTS);

  // Longest reply message in stream words
  localparam int RPL_MAX_WORDS = 2;

  // User reset pulse length and the width of its down counter
  localparam int USR_RST_CYCLES = 16;
  localparam int USR_RST_BITS   = $clog2(USR_RST_CYCLES);

  // Reported in the status reply
  localparam logic [31:0] BUILD_ID = 32'hC3D0_0107;

  // Command codes, upper byte is the message type
  localparam logic [15:0] CMD_STATUS = 16'h0001;
  localparam logic [15:0] CMD_RESET  = 16'h0002;
  localparam logic [15:0] CMD_VERIFY = 16'h0101;
  localparam logic [15:0] RPL_IGNORE = 16'h00FE;

  // Set in a request code to form its reply code
  localparam logic [15:0] RPL_FLAG = 16'h0080;

endpackage

/* logic/cmd_types_pkg.sv */
// Stream word, header, reply message, verdict and handler state types
package cmd_types_pkg;
  import cmd_cfg_pkg::*;

  // One stream beat of payload
  typedef logic [DAT_BITS-1:0] word_t;

  // Valid bytes on an eop beat, 0 means a full word
  typedef logic [MOD_BITS-1:0] mod_t;

  // Upper byte message type, lower byte code
  typedef logic [15:0] cmd_t;

  // First word of every request and reply
  typedef struct packed {
    logic [31:0] tag;
    logic [15:0] len;
    cmd_t        cmd;
  } header_t;

  // Reply message, word 0 in the low half goes out first
  typedef logic [RPL_MAX_WORDS*DAT_BITS-1:0] rpl_msg_t;

  // Number of words in a reply
  typedef logic [$clog2(RPL_MAX_WORDS+1)-1:0] rpl_words_t;

  // Verdict mask from the verify engine
  typedef logic [31:0] result_t;

  // Type-0 handler
  typedef enum logic [2:0] {
    TYP0_IDLE       = 3'd0,
    TYP0_STATUS     = 3'd1,
    TYP0_RESET_WAIT = 3'd2,
    TYP0_SEND       = 3'd3,
    TYP0_DRAIN      = 3'd4
  } typ0_state_t;

  // Type-1 handler, encoding is reported in the status reply
  typedef enum logic [2:0] {
    TYP1_IDLE        = 3'd0,
    TYP1_INDEX       = 3'd1,
    TYP1_FORWARD     = 3'd2,
    TYP1_WAIT_RESULT = 3'd3,
    TYP1_SEND        = 3'd4,
    TYP1_DRAIN       = 3'd5
  } typ1_state_t;

endpackage

/* logic/pkt_stream_if.sv */
// Valid/ready packet stream interface with source and sink modports
`timescale 1ns/1ps

interface pkt_stream_if
  import cmd_types_pkg::*;
();

  // Payload word
  word_t dat;
  // Handshake, a beat moves when both are high
  logic  val;
  logic  rdy;
  // Packet boundaries
  logic  sop;
  logic  eop;
  // Valid bytes of the eop beat
  mod_t  mod;

  // Driver side of the stream
  modport source (
    output dat, val, sop, eop, mod,
    input  rdy
  );

  // Receiver side of the stream
  modport sink (
    input  dat, val, sop, eop, mod,
    output rdy
  );

endinterface

/* logic/cmd_demux.sv */
// Packet router that steers each inbound packet to the type-0 or type-1 queue
`timescale 1ns/1ps

module cmd_demux
  import cmd_types_pkg::*;
(
  input  logic         i_clk_core,
  input  logic         i_rst_core,
  pkt_stream_if.sink   s,
  pkt_stream_if.source o0,
  pkt_stream_if.source o1
);

  header_t hdr;
  // 0 selects queue 0, 1 selects queue 1
  logic    sel;
  logic    sel_l;

  assign hdr = s.dat;

  // Decode the type byte on sop, otherwise keep the packet's queue
  always_comb begin
    if (s.sop) begin
      sel = (hdr.cmd[15:8] != 8'd0);
    end else begin
      sel = sel_l;
    end
  end

  // Beat fields go to both queues, only one sees val
  assign o0.dat = s.dat;
  assign o0.sop = s.sop;
  assign o0.eop = s.eop;
  assign o0.mod = s.mod;
  assign o0.val = s.val && !sel;

  assign o1.dat = s.dat;
  assign o1.sop = s.sop;
  assign o1.eop = s.eop;
  assign o1.mod = s.mod;
  assign o1.val = s.val && sel;

  // Back-pressure from the selected queue only
  assign s.rdy = sel ? o1.rdy : o0.rdy;

  // Remember the choice once the header beat is taken
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      sel_l <= 1'b0;
    end else if (s.val && s.rdy && s.sop) begin
      sel_l <= sel;
    end
  end

  // A stalled beat keeps its header so the queue choice cannot move
  a_in_hold: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (s.val && !s.rdy) |=> (s.val && $stable(s.sop) && $stable(s.dat)));

endmodule

/* logic/cmd_fifo.sv */
// Synchronous packet-stream FIFO with count-based full and empty tracking
`timescale 1ns/1ps

module cmd_fifo
  import cmd_types_pkg::*;
#(
  parameter int DEPTH = 32
)(
  input  logic         i_clk_core,
  input  logic         i_rst_core,
  pkt_stream_if.sink   s,
  pkt_stream_if.source m
);

  // One stored beat
  typedef struct packed {
    word_t dat;
    logic  sop;
    logic  eop;
    mod_t  mod;
  } beat_t;

  beat_t                      mem [DEPTH];
  beat_t                      rd_beat;
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] cnt;
  logic [$clog2(DEPTH+1)-1:0] cnt_nxt;
  logic                       wr;
  logic                       rd;
  logic                       in_rdy;

  assign wr = s.val && in_rdy;
  assign rd = m.val && m.rdy;

  // Occupancy after this edge
  always_comb begin
    cnt_nxt = cnt;
    if (wr && !rd) begin
      cnt_nxt = cnt + 1'b1;
    end else if (rd && !wr) begin
      cnt_nxt = cnt - 1'b1;
    end
  end

  // Pointers wrap at DEPTH so any depth works
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      in_rdy <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      cnt    <= cnt_nxt;
      // Registered so rdy stays low through reset
      in_rdy <= (cnt_nxt != DEPTH);
    end
  end

  // Storage
  always_ff @(posedge i_clk_core) begin
    if (wr) begin
      mem[wr_ptr] <= '{dat: s.dat, sop: s.sop, eop: s.eop, mod: s.mod};
    end
  end

  assign s.rdy   = in_rdy;
  // Head of queue, shows up the cycle after its write
  assign rd_beat = mem[rd_ptr];
  assign m.val   = (cnt != 0);
  assign m.dat   = rd_beat.dat;
  assign m.sop   = rd_beat.sop;
  assign m.eop   = rd_beat.eop;
  assign m.mod   = rd_beat.mod;

  // Pointers only meet when the FIFO is empty or full
  a_ptr_cnt: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (wr_ptr == rd_ptr) |-> ((cnt == 0) || (cnt == DEPTH)));

endmodule

/* logic/reply_serializer.sv */
// Reply serializer that sends a loaded message out as a word packet
`timescale 1ns/1ps

module reply_serializer
  import cmd_cfg_pkg::*, cmd_types_pkg::*;
(
  input  logic         i_clk_core,
  input  logic         i_rst_core,
  input  logic         i_load,
  input  rpl_msg_t     i_msg,
  input  rpl_words_t   i_words,
  output logic         o_busy,
  pkt_stream_if.source m
);

  rpl_msg_t   msg_q;
  // Words still to send, including the one on the bus
  rpl_words_t left;
  logic       val_q;
  logic       sop_q;

  // Load only when idle, then one word per accepted beat
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      val_q <= 1'b0;
      sop_q <= 1'b0;
      left  <= '0;
    end else if (!val_q) begin
      if (i_load) begin
        val_q <= 1'b1;
        sop_q <= 1'b1;
        left  <= i_words;
      end
    end else if (m.rdy) begin
      sop_q <= 1'b0;
      left  <= left - 1'b1;
      // Last word gone
      if (left == 1) begin
        val_q <= 1'b0;
      end
    end
  end

  // Message shifts down so word 0 leaves first
  always_ff @(posedge i_clk_core) begin
    if (i_load && !val_q) begin
      msg_q <= i_msg;
    end else if (val_q && m.rdy) begin
      msg_q <= msg_q >> DAT_BITS;
    end
  end

  assign m.dat  = msg_q[DAT_BITS-1:0];
  assign m.val  = val_q;
  assign m.sop  = sop_q;
  assign m.eop  = (left == 1);
  // Replies are whole words
  assign m.mod  = '0;
  assign o_busy = val_q;

  // Loads only reach an idle serializer with a count it can send
  a_load: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    i_load |-> (!o_busy && (i_words != 0) && (i_words <= RPL_MAX_WORDS)));

endmodule

/* logic/reply_arb.sv */
// Two-input round-robin packet arbiter that holds its grant until end of packet
`timescale 1ns/1ps

module reply_arb (
  input  logic         i_clk_core,
  input  logic         i_rst_core,
  pkt_stream_if.sink   s0,
  pkt_stream_if.sink   s1,
  pkt_stream_if.source m
);

  // Input presented this cycle
  logic sel;
  // Input owning the packet in flight
  logic gnt;
  // Input that finished the last packet
  logic last;
  logic locked;

  // Free choice only between packets
  always_comb begin
    if (locked) begin
      sel = gnt;
    end else if (s0.val && s1.val) begin
      sel = ~last;
    end else begin
      sel = s1.val;
    end
  end

  assign m.dat  = sel ? s1.dat : s0.dat;
  assign m.val  = sel ? s1.val : s0.val;
  assign m.sop  = sel ? s1.sop : s0.sop;
  assign m.eop  = sel ? s1.eop : s0.eop;
  assign m.mod  = sel ? s1.mod : s0.mod;
  assign s0.rdy = m.rdy && !sel;
  assign s1.rdy = m.rdy && sel;

  // Lock as soon as a beat is offered, a stalled beat must not switch source
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      locked <= 1'b0;
      gnt    <= 1'b0;
      // Input 0 goes first after reset
      last   <= 1'b1;
    end else if (m.val) begin
      gnt <= sel;
      if (m.rdy && m.eop) begin
        locked <= 1'b0;
        last   <= sel;
      end else begin
        locked <= 1'b1;
      end
    end
  end

  // After a mid-packet transfer the next beat continues that packet
  a_grant_hold: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (m.val && m.rdy && !m.eop) |=> (m.val && !m.sop));

endmodule

/* logic/cmd_ctrl.sv */
// Type-0 and type-1 command handlers, user reset timer and engine forwarding
`timescale 1ns/1ps

module cmd_ctrl
  import cmd_cfg_pkg::*, cmd_types_pkg::*;
(
  input  logic       i_clk_core,
  input  logic       i_rst_core,
  pkt_stream_if.sink q0,
  pkt_stream_if.sink q1,
  output logic       o_usr_rst,
  output word_t      o_eng_dat,
  output logic       o_eng_val,
  output logic       o_eng_sop,
  output logic       o_eng_eop,
  output mod_t       o_eng_mod,
  input  logic       i_eng_rdy,
  input  result_t    i_eng_result,
  input  logic       i_eng_result_val,
  output logic       o_ld0,
  output rpl_msg_t   o_msg0,
  output rpl_words_t o_words0,
  input  logic       i_busy0,
  output logic       o_ld1,
  output rpl_msg_t   o_msg1,
  output rpl_words_t o_words1,
  input  logic       i_busy1
);

  typ0_state_t             st0;
  typ1_state_t             st1;
  header_t                 hdr0;
  header_t                 hdr1;
  logic                    eop0_l;
  logic [USR_RST_BITS-1:0] rst_cnt;
  logic [31:0]             index_lo;
  logic                    eng_first;

  // Reply header word
  function automatic word_t rpl_hdr(input logic [31:0] tag, input logic [15:0] len,
                                    input cmd_t cmd);
    header_t h;
    h.tag = tag;
    h.len = len;
    h.cmd = cmd;
    return h;
  endfunction

  assign hdr0 = q0.dat;
  assign hdr1 = q1.dat;

  // Queue back-pressure by state, forwarding follows the engine
  always_comb begin
    q0.rdy = (st0 == TYP0_IDLE) || (st0 == TYP0_DRAIN);
    case (st1)
      TYP1_IDLE, TYP1_INDEX, TYP1_DRAIN: q1.rdy = 1'b1;
      TYP1_FORWARD:                      q1.rdy = i_eng_rdy;
      default:                           q1.rdy = 1'b0;
    endcase
  end

  // Payload beats pass straight to the engine
  assign o_eng_dat = q1.dat;
  assign o_eng_val = q1.val && (st1 == TYP1_FORWARD);
  assign o_eng_sop = eng_first;
  assign o_eng_eop = q1.eop;
  assign o_eng_mod = q1.mod;

  // Serializer loads fire on the edge that leaves SEND
  assign o_ld0    = (st0 == TYP0_SEND) && !i_busy0;
  assign o_ld1    = (st1 == TYP1_SEND) && !i_busy1;
  assign o_words1 = rpl_words_t'(RPL_MAX_WORDS);

  // Type-0 handler
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      st0       <= TYP0_IDLE;
      o_usr_rst <= 1'b0;
      rst_cnt   <= '0;
    end else begin
      case (st0)
        TYP0_IDLE: begin
          if (q0.val) begin
            case (hdr0.cmd)
              CMD_STATUS: st0 <= TYP0_STATUS;
              CMD_RESET: begin
                st0       <= TYP0_RESET_WAIT;
                o_usr_rst <= 1'b1;
                rst_cnt   <= USR_RST_BITS'(USR_RST_CYCLES - 1);
              end
              default:    st0 <= TYP0_SEND;
            endcase
          end
        end
        TYP0_STATUS: st0 <= TYP0_SEND;
        // Pulse counts down, reply waits for its end
        TYP0_RESET_WAIT: begin
          if (rst_cnt == 0) begin
            o_usr_rst <= 1'b0;
            st0       <= TYP0_SEND;
          end else begin
            rst_cnt <= rst_cnt - 1'b1;
          end
        end
        TYP0_SEND: begin
          if (!i_busy0) begin
            st0 <= eop0_l ? TYP0_IDLE : TYP0_DRAIN;
          end
        end
        // Rest of a multi-beat packet
        TYP0_DRAIN: begin
          if (q0.val && q0.eop) begin
            st0 <= TYP0_IDLE;
          end
        end
        default: st0 <= TYP0_IDLE;
      endcase
    end
  end

  // Type-0 reply words
  always_ff @(posedge i_clk_core) begin
    if (st0 == TYP0_IDLE && q0.val) begin
      eop0_l   <= q0.eop;
      o_words0 <= (hdr0.cmd == CMD_STATUS) ? rpl_words_t'(RPL_MAX_WORDS) : rpl_words_t'(1);
      case (hdr0.cmd)
        CMD_STATUS: o_msg0[DAT_BITS-1:0] <=
          rpl_hdr(hdr0.tag, 16'(2 * DAT_BYTS), CMD_STATUS | RPL_FLAG);
        CMD_RESET:  o_msg0[DAT_BITS-1:0] <=
          rpl_hdr(hdr0.tag, 16'(DAT_BYTS), CMD_RESET | RPL_FLAG);
        // Unknown code goes back as the tag
        default:    o_msg0[DAT_BITS-1:0] <=
          rpl_hdr({16'd0, hdr0.cmd}, 16'(DAT_BYTS), RPL_IGNORE);
      endcase
    end
    // Snapshot of the type-1 handler
    if (st0 == TYP0_STATUS) begin
      o_msg0[2*DAT_BITS-1 -: DAT_BITS] <= {BUILD_ID, 24'd0, 8'(st1)};
    end
  end

  // Type-1 handler
  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      st1       <= TYP1_IDLE;
      eng_first <= 1'b0;
    end else begin
      case (st1)
        TYP1_IDLE: begin
          // Single-beat unknown packets end here
          if (q1.val && !q1.eop) begin
            st1 <= (hdr1.cmd == CMD_VERIFY) ? TYP1_INDEX : TYP1_DRAIN;
          end
        end
        TYP1_INDEX: begin
          if (q1.val) begin
            eng_first <= 1'b1;
            st1       <= q1.eop ? TYP1_WAIT_RESULT : TYP1_FORWARD;
          end
        end
        TYP1_FORWARD: begin
          if (q1.val && q1.rdy) begin
            eng_first <= 1'b0;
            if (q1.eop) begin
              st1 <= TYP1_WAIT_RESULT;
            end
          end
        end
        TYP1_WAIT_RESULT: begin
          if (i_eng_result_val) begin
            st1 <= TYP1_SEND;
          end
        end
        TYP1_SEND: begin
          if (!i_busy1) begin
            st1 <= TYP1_IDLE;
          end
        end
        TYP1_DRAIN: begin
          if (q1.val && q1.eop) begin
            st1 <= TYP1_IDLE;
          end
        end
        default: st1 <= TYP1_IDLE;
      endcase
    end
  end

  // Verify reply words, header from the request and verdict with index
  always_ff @(posedge i_clk_core) begin
    if (st1 == TYP1_IDLE && q1.val) begin
      o_msg1[DAT_BITS-1:0] <= rpl_hdr(hdr1.tag, 16'(2 * DAT_BYTS), CMD_VERIFY | RPL_FLAG);
    end
    if (st1 == TYP1_INDEX && q1.val) begin
      index_lo <= q1.dat[31:0];
    end
    if (st1 == TYP1_WAIT_RESULT && i_eng_result_val) begin
      o_msg1[2*DAT_BITS-1 -: DAT_BITS] <= {i_eng_result, index_lo};
    end
  end

endmodule

/* logic/cmd_top.sv */
// Command processor top level with plain stream ports and interface wiring
`timescale 1ns/1ps

module cmd_top
  import cmd_types_pkg::*;
(
  input  logic    i_clk_core,
  input  logic    i_rst_core,
  // Host command stream
  input  word_t   i_rx_dat,
  input  logic    i_rx_val,
  output logic    o_rx_rdy,
  input  logic    i_rx_sop,
  input  logic    i_rx_eop,
  input  mod_t    i_rx_mod,
  // Reply stream
  output word_t   o_tx_dat,
  output logic    o_tx_val,
  input  logic    i_tx_rdy,
  output logic    o_tx_sop,
  output logic    o_tx_eop,
  output mod_t    o_tx_mod,
  output logic    o_usr_rst,
  // Verify engine
  output word_t   o_eng_dat,
  output logic    o_eng_val,
  input  logic    i_eng_rdy,
  output logic    o_eng_sop,
  output logic    o_eng_eop,
  output mod_t    o_eng_mod,
  input  result_t i_eng_result,
  input  logic    i_eng_result_val
);

  pkt_stream_if rx_if ();
  pkt_stream_if q0_in_if ();
  pkt_stream_if q1_in_if ();
  pkt_stream_if q0_if ();
  pkt_stream_if q1_if ();
  pkt_stream_if rpl0_if ();
  pkt_stream_if rpl1_if ();
  pkt_stream_if tx_if ();

  // Controller to serializer handoff
  logic       ld0;
  logic       ld1;
  logic       busy0;
  logic       busy1;
  rpl_msg_t   msg0;
  rpl_msg_t   msg1;
  rpl_words_t words0;
  rpl_words_t words1;

  assign rx_if.dat = i_rx_dat;
  assign rx_if.val = i_rx_val;
  assign rx_if.sop = i_rx_sop;
  assign rx_if.eop = i_rx_eop;
  assign rx_if.mod = i_rx_mod;
  assign o_rx_rdy  = rx_if.rdy;

  assign o_tx_dat  = tx_if.dat;
  assign o_tx_val  = tx_if.val;
  assign o_tx_sop  = tx_if.sop;
  assign o_tx_eop  = tx_if.eop;
  assign o_tx_mod  = tx_if.mod;
  assign tx_if.rdy = i_tx_rdy;

  cmd_demux u_demux (.i_clk_core, .i_rst_core, .s(rx_if), .o0(q0_in_if), .o1(q1_in_if));

  // Status and reset queue, kept apart so it is served during verifies
  cmd_fifo #(.DEPTH(32)) u_q0 (.i_clk_core, .i_rst_core, .s(q0_in_if), .m(q0_if));
  cmd_fifo #(.DEPTH(32)) u_q1 (.i_clk_core, .i_rst_core, .s(q1_in_if), .m(q1_if));

  cmd_ctrl u_ctrl (
    .i_clk_core, .i_rst_core,
    .q0 (q0_if),
    .q1 (q1_if),
    .o_usr_rst,
    .o_eng_dat, .o_eng_val, .o_eng_sop, .o_eng_eop, .o_eng_mod, .i_eng_rdy,
    .i_eng_result, .i_eng_result_val,
    .o_ld0 (ld0), .o_msg0 (msg0), .o_words0 (words0), .i_busy0 (busy0),
    .o_ld1 (ld1), .o_msg1 (msg1), .o_words1 (words1), .i_busy1 (busy1)
  );

  reply_serializer u_ser0 (
    .i_clk_core, .i_rst_core,
    .i_load (ld0), .i_msg (msg0), .i_words (words0), .o_busy (busy0), .m (rpl0_if)
  );

  reply_serializer u_ser1 (
    .i_clk_core, .i_rst_core,
    .i_load (ld1), .i_msg (msg1), .i_words (words1), .o_busy (busy1), .m (rpl1_if)
  );

  reply_arb u_arb (.i_clk_core, .i_rst_core, .s0(rpl0_if), .s1(rpl1_if), .m(tx_if));

endmodule

/* tb/tb_cmd_top.sv */
// Testbench for cmd_top with reply reference model, tx compare process and engine monitor
`timescale 1ns/1ps

module tb_cmd_top
  import cmd_cfg_pkg::*, cmd_types_pkg::*;
();

  logic    i_clk_core;
  logic    i_rst_core;
  word_t   i_rx_dat;
  logic    i_rx_val;
  logic    o_rx_rdy;
  logic    i_rx_sop;
  logic    i_rx_eop;
  mod_t    i_rx_mod;
  word_t   o_tx_dat;
  logic    o_tx_val;
  logic    i_tx_rdy;
  logic    o_tx_sop;
  logic    o_tx_eop;
  mod_t    o_tx_mod;
  logic    o_usr_rst;
  word_t   o_eng_dat;
  logic    o_eng_val;
  logic    i_eng_rdy;
  logic    o_eng_sop;
  logic    o_eng_eop;
  mod_t    o_eng_mod;
  result_t i_eng_result;
  logic    i_eng_result_val;

  // Beat the engine should see
  typedef struct packed {
    logic  sop;
    logic  eop;
    mod_t  mod;
    word_t dat;
  } eng_beat_t;

  // Expected reply words and packet lengths, one pair per message type
  word_t     exp_q0[$];
  word_t     exp_q1[$];
  int        len_q0[$];
  int        len_q1[$];
  eng_beat_t eng_q[$];
  result_t   mask_q[$];
  // Request being built for the rx side
  word_t     rx_words[$];
  // Valid bytes of the request's last beat
  mod_t      rx_eop_mod;
  string     test_name;
  int        err_cnt;
  int        fail_cnt;
  bit        abort;
  // Reply packet currently on tx
  bit        in_pkt;
  bit        cur_typ;
  int        cur_len;
  int        cur_pos;
  int        rpl_started;
  int        eng_eops;
  int        results_given;
  word_t     exp_w;
  eng_beat_t exp_b;
  bit        typ1;
  bit        have;

  cmd_top u_cmd_top (.*);

  initial begin
    i_clk_core = 1'b0;
    forever #10 i_clk_core = ~i_clk_core;
  end

  // Ready gaps on reply and engine side, roughly one cycle in four low
  always @(posedge i_clk_core) begin
    #1;
    i_tx_rdy  = ($urandom % 4) != 0;
    i_eng_rdy = ($urandom % 4) != 0;
  end

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic note_fail(input string msg);
    $display("FAIL [%s] %s", test_name, msg);
    fail_cnt++;
  endtask

  task automatic report_timeout(input string what);
    note_fail({"timed out waiting for ", what});
    abort = 1'b1;
  endtask

  // Reference model of the reply to one request
  function automatic void expect_reply(input logic [15:0] cmd, input logic [31:0] tag,
                                       input logic [31:0] aux, input result_t mask);
    if (cmd == CMD_STATUS) begin
      exp_q0.push_back({tag, 16'd16, CMD_STATUS | RPL_FLAG});
      // Low byte of aux is the type-1 state
      exp_q0.push_back({BUILD_ID, aux});
      len_q0.push_back(2);
    end else if (cmd == CMD_RESET) begin
      exp_q0.push_back({tag, 16'd8, CMD_RESET | RPL_FLAG});
      len_q0.push_back(1);
    end else if (cmd[15:8] == 8'h00) begin
      // Unknown type-0 code comes back as the tag
      exp_q0.push_back({16'd0, cmd, 16'd8, RPL_IGNORE});
      len_q0.push_back(1);
    end else if (cmd == CMD_VERIFY) begin
      exp_q1.push_back({tag, 16'd16, CMD_VERIFY | RPL_FLAG});
      exp_q1.push_back({mask, aux});
      len_q1.push_back(2);
    end
    // Other type-1 codes are drained silently
  endfunction

  // Send rx_words as one packet, one beat per accepted handshake
  task automatic send_pkt();
    int wait_cyc;
    bit acc;
    for (int i = 0; i < rx_words.size(); i++) begin
      i_rx_dat = rx_words[i];
      i_rx_sop = (i == 0);
      i_rx_eop = (i == rx_words.size() - 1);
      i_rx_mod = (i == rx_words.size() - 1) ? rx_eop_mod : '0;
      i_rx_val = 1'b1;
      acc      = 1'b0;
      wait_cyc = 0;
      while (!acc && !abort) begin
        @(negedge i_clk_core);
        acc = o_rx_rdy;
        @(posedge i_clk_core);
        #1;
        wait_cyc++;
        if (!acc && wait_cyc >= 200) begin
          report_timeout("o_rx_rdy");
        end
      end
    end
    i_rx_val   = 1'b0;
    i_rx_sop   = 1'b0;
    i_rx_eop   = 1'b0;
    i_rx_mod   = '0;
    rx_eop_mod = '0;
    rx_words.delete();
  endtask

  // Header plus extra random words
  task automatic send_cmd(input logic [15:0] cmd, input logic [31:0] aux, input int extra);
    logic [31:0] tag;
    tag = $urandom;
    rx_words.push_back({tag, 16'((extra + 1) * DAT_BYTS), cmd});
    for (int i = 0; i < extra; i++) begin
      rx_words.push_back({$urandom, $urandom});
    end
    expect_reply(cmd, tag, aux, '0);
    send_pkt();
  endtask

  // Header, index word and 4 payload beats for the engine
  task automatic send_verify();
    logic [31:0] tag;
    word_t       index;
    result_t     mask;
    eng_beat_t   beat;
    tag        = $urandom;
    index      = {$urandom, $urandom};
    mask       = $urandom;
    rx_eop_mod = mod_t'($urandom);
    rx_words.push_back({tag, 16'(6 * DAT_BYTS), CMD_VERIFY});
    rx_words.push_back(index);
    for (int i = 0; i < 4; i++) begin
      beat.sop = (i == 0);
      beat.eop = (i == 3);
      beat.mod = (i == 3) ? rx_eop_mod : '0;
      beat.dat = {$urandom, $urandom};
      rx_words.push_back(beat.dat);
      eng_q.push_back(beat);
    end
    mask_q.push_back(mask);
    expect_reply(CMD_VERIFY, tag, index[31:0], mask);
    send_pkt();
  endtask

  task automatic wait_engine(input int n);
    int wait_cyc;
    wait_cyc = 0;
    while (eng_eops < n && !abort) begin
      @(posedge i_clk_core);
      #1;
      wait_cyc++;
      if (eng_eops < n && wait_cyc >= 2000) begin
        report_timeout("the engine eop beat");
      end
    end
  endtask

  // One-cycle verdict pulse once the next forwarded packet has ended
  task automatic give_result();
    wait_engine(results_given + 1);
    if (abort) begin
      return;
    end
    i_eng_result     = mask_q.pop_front();
    i_eng_result_val = 1'b1;
    @(posedge i_clk_core);
    #1;
    i_eng_result_val = 1'b0;
    results_given++;
  endtask

  // Until every expected reply is in, or only the type-0 ones
  task automatic wait_replies(input bit only0);
    int wait_cyc;
    bit busy;
    wait_cyc = 0;
    busy     = 1'b1;
    while (busy && !abort) begin
      @(posedge i_clk_core);
      #1;
      busy = (len_q0.size() > 0) || (in_pkt && !cur_typ);
      if (!only0) begin
        busy = busy || (len_q1.size() > 0) || in_pkt;
      end
      wait_cyc++;
      if (busy && wait_cyc >= 4000) begin
        report_timeout("replies");
      end
    end
  endtask

  task automatic test_reset();
    int hi;
    int wait_cyc;
    int started;
    test_name = "reset";
    started   = rpl_started;
    send_cmd(CMD_RESET, '0, 0);
    wait_cyc = 0;
    while (!o_usr_rst && !abort) begin
      @(negedge i_clk_core);
      wait_cyc++;
      if (!o_usr_rst && wait_cyc >= 100) begin
        report_timeout("o_usr_rst to rise");
      end
    end
    // Count the cycles of the pulse
    hi = 0;
    while (o_usr_rst && !abort) begin
      hi++;
      @(negedge i_clk_core);
      if (o_usr_rst && hi >= 100) begin
        report_timeout("o_usr_rst to fall");
      end
    end
    check_val("usr_rst cycles", USR_RST_CYCLES, hi);
    assert (rpl_started == started) else note_fail("reset reply started during o_usr_rst");
    wait_replies(1'b0);
  endtask

  task automatic test_busy_mix();
    test_name = "busy_mix";
    send_verify();
    wait_engine(results_given + 1);
    // Type 1 now sits in WAIT_RESULT
    send_cmd(CMD_STATUS, 32'(TYP1_WAIT_RESULT), 0);
    wait_replies(1'b1);
    give_result();
    wait_replies(1'b0);
    // Mixed burst, order kept per message type
    send_verify();
    send_cmd(16'h0041, '0, 0);
    send_cmd(16'h0042, '0, 1);
    give_result();
    send_verify();
    send_cmd(16'h0043, '0, 0);
    give_result();
    wait_replies(1'b0);
  endtask

  // Compare process for accepted tx beats
  always @(negedge i_clk_core) begin
    if (!i_rst_core && o_tx_val && i_tx_rdy) begin
      if (!in_pkt) begin
        assert (o_tx_sop) else note_fail("reply beat outside a packet without sop");
        typ1 = (o_tx_dat[15:8] != 8'd0);
        have = typ1 ? (len_q1.size() > 0) : (len_q0.size() > 0);
        assert (have) else note_fail("a reply arrived that no request asked for");
        if (have) begin
          cur_typ = typ1;
          cur_len = typ1 ? len_q1.pop_front() : len_q0.pop_front();
          cur_pos = 0;
          in_pkt  = 1'b1;
          rpl_started++;
        end
      end
      if (in_pkt) begin
        exp_w = cur_typ ? exp_q1.pop_front() : exp_q0.pop_front();
        check_val("tx dat", exp_w, o_tx_dat);
        check_val("tx sop", cur_pos == 0, o_tx_sop);
        check_val("tx eop", cur_pos == cur_len - 1, o_tx_eop);
        check_val("tx mod", '0, o_tx_mod);
        cur_pos++;
        if (cur_pos == cur_len) begin
          in_pkt = 1'b0;
        end
      end
    end
  end

  // Engine monitor
  always @(negedge i_clk_core) begin
    if (!i_rst_core && o_eng_val && i_eng_rdy) begin
      assert (eng_q.size() > 0) else note_fail("engine got a beat that was not expected");
      if (eng_q.size() > 0) begin
        exp_b = eng_q.pop_front();
        check_val("eng dat", exp_b.dat, o_eng_dat);
        check_val("eng sop", exp_b.sop, o_eng_sop);
        check_val("eng eop", exp_b.eop, o_eng_eop);
        check_val("eng mod", exp_b.mod, o_eng_mod);
      end
      if (o_eng_eop) begin
        eng_eops++;
      end
    end
  end

  initial begin
    void'($urandom(97398));
    test_name        = "init";
    i_rst_core       = 1'b1;
    i_rx_dat         = '0;
    i_rx_val         = 1'b0;
    i_rx_sop         = 1'b0;
    i_rx_eop         = 1'b0;
    i_rx_mod         = '0;
    rx_eop_mod       = '0;
    i_tx_rdy         = 1'b1;
    i_eng_rdy        = 1'b1;
    i_eng_result     = '0;
    i_eng_result_val = 1'b0;
    repeat (4) @(posedge i_clk_core);
    #1;
    assert (!o_tx_val && !o_eng_val && !o_usr_rst && !o_rx_rdy)
      else note_fail("outputs active during reset");
    i_rst_core = 1'b0;

    test_name = "status";
    send_cmd(CMD_STATUS, '0, 0);
    wait_replies(1'b0);
    if (!abort) begin
      test_reset();
    end
    // Ignore reply, then a drained type-1 packet and a status behind it
    if (!abort) begin
      test_name = "unknown";
      send_cmd(16'h0033, '0, 2);
      wait_replies(1'b0);
      send_cmd(16'h0177, '0, 1);
      send_cmd(CMD_STATUS, '0, 0);
      wait_replies(1'b0);
    end
    if (!abort) begin
      test_name = "verify";
      send_verify();
      give_result();
      wait_replies(1'b0);
    end
    if (!abort) begin
      test_busy_mix();
    end
    if (!abort) begin
      assert (eng_q.size() == 0) else note_fail("payload beats never reached the engine");
    end

    $display("Closing: %0d value errors, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* cmd_proc.f */
logic/cmd_cfg_pkg.sv
logic/cmd_types_pkg.sv
logic/pkt_stream_if.sv
logic/cmd_demux.sv
logic/cmd_fifo.sv
logic/reply_serializer.sv
logic/reply_arb.sv
logic/cmd_ctrl.sv
logic/cmd_top.sv
tb/tb_cmd_top.sv

/* Makefile */
# Verilator build and run of the cmd_proc testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cmd_top \
		-f cmd_proc.f -Mdir obj_dir
	./obj_dir/Vtb_cmd_top | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
